/* design/avr_pkg.sv */
// avr_pkg
// shared widths, opcode field types, state enums and control structs
// for the two-stage AVR core
package avr_pkg;

	// data byte, instruction word and register number
	typedef logic [7:0] byte_t;
	typedef logic [15:0] word_t;
	typedef logic [4:0] reg_sel_t;

	// relative jump distance in words, branches are sign-extended into it
	typedef logic signed [11:0] offset_t;

	// status register bit positions
	localparam int SREG_C = 0;
	localparam int SREG_Z = 1;
	localparam int SREG_N = 2;
	localparam int SREG_V = 3;
	localparam int SREG_S = 4;
	localparam int SREG_H = 5;

	// alu operations, com/inc/dec carry their own flag rules
	typedef enum logic [3:0] {
		ALU_MOVD,
		ALU_MOVR,
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_EOR,
		ALU_NEG,
		ALU_SWAP,
		ALU_LSR,
		ALU_ASR,
		ALU_ROR,
		ALU_COM,
		ALU_INC,
		ALU_DEC
	} alu_op_t;

	typedef enum logic [2:0] {
		CLS_ALU,
		CLS_LDS,
		CLS_STS,
		CLS_BRANCH,
		CLS_RJMP,
		CLS_NOP
	} instr_class_t;

	// cycle within a multi-cycle instruction
	typedef enum logic [1:0] {
		ST_FIRST,
		ST_ADDRESS,
		ST_LOAD
	} seq_state_t;

	typedef enum logic [1:0] {
		PC_ADVANCE,
		PC_HOLD,
		PC_RELATIVE,
		PC_BRANCH
	} pc_step_t;

	// controls handed from decode to the execute stage
	typedef struct packed {
		alu_op_t op;
		logic store;
		logic carry;
		logic use_const;
		byte_t const_val;
		reg_sel_t dst;
		logic flag_en;
	} exec_ctl_t;

	typedef struct packed {
		instr_class_t cls;
		exec_ctl_t ctl;
		reg_sel_t sel_a;
		reg_sel_t sel_b;
		offset_t offset;
		logic [2:0] flag_idx;
		logic polarity;
	} decoded_t;

	typedef struct packed {
		logic we;
		reg_sel_t dst;
		byte_t data;
	} reg_write_t;

endpackage

/* design/avr_decode.sv */
// avr_decode
// instruction decoder of the first pipeline stage
// takes the fetched word in the first cycle and the held opcode in the
// later cycles of LDS, STS and branches, and produces register selects,
// execute controls and jump fields
`timescale 1ns/1ns

module avr_decode import avr_pkg::*; (
	input logic clk,
	input logic reset,
	input word_t cdata,
	input seq_state_t state,
	output decoded_t dec
);

	word_t held_op;
	word_t opcode;

	// opcode fields
	reg_sel_t op_rd;
	reg_sel_t op_rr;
	reg_sel_t op_rdi;
	byte_t op_k;

	// per-row decode results
	instr_class_t cls;
	alu_op_t op;
	logic store;
	logic carry;
	logic imm;
	logic flags;

	// multi-cycle instructions keep decoding their first word
	assign opcode = (state == ST_FIRST) ? cdata : held_op;

	always_ff @(posedge clk) begin
		if (reset)
			held_op <= '0;
		else
			held_op <= opcode;
	end

	assign op_rd = opcode[8:4];
	assign op_rr = {opcode[9], opcode[3:0]};
	// immediate forms reach only r16 to r31
	assign op_rdi = {1'b1, opcode[7:4]};
	assign op_k = {opcode[11:8], opcode[3:0]};

	always_comb begin
		// most rows are stored alu ops with flag update
		cls = CLS_ALU;
		op = ALU_MOVD;
		store = 1'b1;
		carry = 1'b0;
		imm = 1'b0;
		flags = 1'b1;

		casez (opcode)
		16'b0000_0000_0000_0000: cls = CLS_NOP;
		16'b0000_01??_????_????: begin
			// cpc, compare only
			op = ALU_SUB;
			carry = 1'b1;
			store = 1'b0;
		end
		16'b0000_10??_????_????: begin
			op = ALU_SUB;
			carry = 1'b1;
		end
		16'b0000_11??_????_????: op = ALU_ADD;
		16'b0001_01??_????_????: begin
			// cp
			op = ALU_SUB;
			store = 1'b0;
		end
		16'b0001_10??_????_????: op = ALU_SUB;
		16'b0001_11??_????_????: begin
			op = ALU_ADD;
			carry = 1'b1;
		end
		16'b0010_00??_????_????: op = ALU_AND;
		16'b0010_01??_????_????: op = ALU_EOR;
		16'b0010_10??_????_????: op = ALU_OR;
		16'b0010_11??_????_????: begin
			// mov leaves sreg alone
			op = ALU_MOVR;
			flags = 1'b0;
		end
		16'b0011_????_????_????: begin
			// cpi
			op = ALU_SUB;
			imm = 1'b1;
			store = 1'b0;
		end
		16'b0100_????_????_????: begin
			op = ALU_SUB;
			imm = 1'b1;
			carry = 1'b1;
		end
		16'b0101_????_????_????: begin
			op = ALU_SUB;
			imm = 1'b1;
		end
		16'b0110_????_????_????: begin
			op = ALU_OR;
			imm = 1'b1;
		end
		16'b0111_????_????_????: begin
			op = ALU_AND;
			imm = 1'b1;
		end
		16'b1110_????_????_????: begin
			// ldi
			op = ALU_MOVR;
			imm = 1'b1;
			flags = 1'b0;
		end
		16'b1100_????_????_????: cls = CLS_RJMP;
		// brbs and brbc
		16'b1111_0???_????_????: cls = CLS_BRANCH;
		16'b1001_000?_????_0000: begin
			// lds, written back by the load cycle as a move
			cls = CLS_LDS;
			op = ALU_MOVR;
			flags = 1'b0;
		end
		16'b1001_001?_????_0000: cls = CLS_STS;
		16'b1001_010?_????_0000: op = ALU_COM;
		16'b1001_010?_????_0001: op = ALU_NEG;
		16'b1001_010?_????_0010: begin
			op = ALU_SWAP;
			flags = 1'b0;
		end
		16'b1001_010?_????_0011: op = ALU_INC;
		16'b1001_010?_????_0101: op = ALU_ASR;
		16'b1001_010?_????_0110: op = ALU_LSR;
		16'b1001_010?_????_0111: op = ALU_ROR;
		16'b1001_010?_????_1010: op = ALU_DEC;
		default: cls = CLS_NOP;
		endcase

		// control flow, stores and nops touch neither registers nor flags
		if (cls != CLS_ALU && cls != CLS_LDS) begin
			store = 1'b0;
			flags = 1'b0;
		end

		dec.cls = cls;
		dec.ctl.op = op;
		dec.ctl.store = store;
		dec.ctl.carry = carry;
		dec.ctl.use_const = imm;
		dec.ctl.const_val = op_k;
		dec.ctl.dst = imm ? op_rdi : op_rd;
		dec.ctl.flag_en = flags;
		// port a also carries rd for the sts data
		dec.sel_a = imm ? op_rdi : op_rd;
		dec.sel_b = op_rr;
		if (cls == CLS_BRANCH)
			dec.offset = {{5{opcode[9]}}, opcode[9:3]};
		else
			dec.offset = opcode[11:0];
		dec.flag_idx = opcode[2:0];
		// brbc has bit 10 set
		dec.polarity = opcode[10];
	end

endmodule

/* design/avr_sequencer.sv */
// avr_sequencer
// cycle FSM for LDS, STS and branches
// picks the PC step of each cycle, drives the data memory strobes and
// passes the execute controls on, with the load writeback in the last
// LDS cycle
`timescale 1ns/1ns

module avr_sequencer import avr_pkg::*; (
	input logic clk,
	input logic reset,
	input decoded_t dec,
	input word_t cdata,
	input byte_t a_data,
	input byte_t data_read,
	output seq_state_t state,
	output pc_step_t step,
	output exec_ctl_t ctl,
	output word_t data_addr,
	output logic data_wen,
	output logic data_ren,
	output byte_t data_write
);

	seq_state_t state_next;
	logic last;

	always_ff @(posedge clk) begin
		if (reset)
			state <= ST_FIRST;
		else
			state <= state_next;
	end

	always_comb begin
		state_next = ST_FIRST;
		step = PC_ADVANCE;
		last = 1'b1;
		case (state)
		ST_FIRST: begin
			if (dec.cls == CLS_LDS || dec.cls == CLS_STS) begin
				// fetch the address word next
				state_next = ST_ADDRESS;
				last = 1'b0;
			end else if (dec.cls == CLS_BRANCH) begin
				// wait one clock for the sreg of the previous op
				state_next = ST_ADDRESS;
				step = PC_HOLD;
				last = 1'b0;
			end else if (dec.cls == CLS_RJMP) begin
				step = PC_RELATIVE;
			end
		end
		ST_ADDRESS: begin
			if (dec.cls == CLS_LDS) begin
				// stay on the address word while the read completes
				state_next = ST_LOAD;
				step = PC_HOLD;
				last = 1'b0;
			end else if (dec.cls == CLS_BRANCH) begin
				step = PC_BRANCH;
			end
		end
		default: begin
			// load cycle, step past the address word
			state_next = ST_FIRST;
		end
		endcase
	end

	// request uses the address word on cdata and rd read on port a
	assign data_addr = cdata;
	assign data_write = a_data;
	assign data_wen = (state == ST_ADDRESS) && (dec.cls == CLS_STS);
	assign data_ren = (state == ST_ADDRESS) && (dec.cls == CLS_LDS);

	always_comb begin
		ctl = dec.ctl;
		ctl.store = dec.ctl.store & last;
		if (state == ST_LOAD) begin
			// write the loaded byte into rd as a constant move
			ctl.op = ALU_MOVR;
			ctl.store = 1'b1;
			ctl.carry = 1'b0;
			ctl.use_const = 1'b1;
			ctl.const_val = data_read;
			ctl.flag_en = 1'b0;
		end
	end

endmodule

/* design/avr_pc.sv */
// avr_pc
// program counter
// the pc output is the next fetch address, the program memory registers
// it so the word at the current PC arrives on cdata
`timescale 1ns/1ns

module avr_pc import avr_pkg::*; #(
	parameter word_t reset_pc = 16'h0000
) (
	input logic clk,
	input logic reset,
	input pc_step_t step,
	input word_t offset,
	input logic [2:0] flag_idx,
	input logic polarity,
	input byte_t sreg,
	output word_t pc
);

	word_t pc_q;
	word_t pc_next;
	word_t target;
	logic taken;

	// relative targets count from the word after the jump
	assign target = pc_q + offset + 16'd1;
	// brbs branches on a set bit, brbc on a clear one
	assign taken = sreg[flag_idx] != polarity;

	always_comb begin
		case (step)
		PC_HOLD: pc_next = pc_q;
		PC_RELATIVE: pc_next = target;
		PC_BRANCH: pc_next = taken ? target : pc_q + 16'd1;
		default: pc_next = pc_q + 16'd1;
		endcase
		// fetch the start word during reset so it is on cdata right after
		if (reset)
			pc_next = reset_pc;
	end

	always_ff @(posedge clk) begin
		pc_q <= pc_next;
	end

	assign pc = pc_next;

endmodule

/* design/avr_regfile.sv */
// avr_regfile
// 32 x 8 register file with two registered read ports
// a read of the register written in the same clock returns the new value
`timescale 1ns/1ns

module avr_regfile import avr_pkg::*; (
	input logic clk,
	input logic reset,
	input reg_sel_t sel_a,
	input reg_sel_t sel_b,
	input reg_write_t wr,
	output byte_t a_data,
	output byte_t b_data
);

	byte_t regs [32];

	// bypass the array when the writeback hits the same register
	function automatic byte_t forward(reg_sel_t sel, reg_write_t w, byte_t stored);
		if (w.we && w.dst == sel)
			return w.data;
		return stored;
	endfunction

	always_ff @(posedge clk) begin
		if (wr.we)
			regs[wr.dst] <= wr.data;
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			a_data <= '0;
			b_data <= '0;
		end else begin
			a_data <= forward(sel_a, wr, regs[sel_a]);
			b_data <= forward(sel_b, wr, regs[sel_b]);
		end
	end

endmodule

/* design/avr_execute.sv */
// avr_execute
// second pipeline stage
// latches the controls for one clock, runs the ALU on the register reads
// or the constant, updates the status register and drives the writeback
`timescale 1ns/1ns

module avr_execute import avr_pkg::*; (
	input logic clk,
	input logic reset,
	input exec_ctl_t ctl,
	input byte_t a_data,
	input byte_t b_data,
	output reg_write_t wr,
	output byte_t sreg
);

	exec_ctl_t ctl_q;
	byte_t rr;
	byte_t res;
	byte_t sub_a;
	byte_t sub_b;
	byte_t sreg_next;
	logic cin;
	logic [8:0] sum;
	logic [8:0] diff;
	logic [4:0] hsum;
	logic [4:0] hdiff;
	logic c_new;
	logic h_new;
	logic v_new;
	logic z_new;
	logic sticky;

	always_ff @(posedge clk) begin
		ctl_q <= ctl;
		if (reset) begin
			ctl_q.store <= 1'b0;
			ctl_q.flag_en <= 1'b0;
		end
	end

	// rr is the second register or the immediate
	assign rr = ctl_q.use_const ? ctl_q.const_val : b_data;
	assign cin = ctl_q.carry & sreg[SREG_C];

	// neg runs as 0 - rd through the subtractor
	assign sub_a = (ctl_q.op == ALU_NEG) ? 8'h00 : a_data;
	assign sub_b = (ctl_q.op == ALU_NEG) ? a_data : rr;

	assign sum = {1'b0, a_data} + {1'b0, rr} + {8'b0, cin};
	assign hsum = {1'b0, a_data[3:0]} + {1'b0, rr[3:0]} + {4'b0, cin};
	assign diff = {1'b0, sub_a} - {1'b0, sub_b} - {8'b0, cin};
	assign hdiff = {1'b0, sub_a[3:0]} - {1'b0, sub_b[3:0]} - {4'b0, cin};

	always_comb begin
		res = a_data;
		// flags not named by an op keep their value
		c_new = sreg[SREG_C];
		h_new = sreg[SREG_H];
		v_new = sreg[SREG_V];
		case (ctl_q.op)
		ALU_MOVR: res = rr;
		ALU_ADD: begin
			res = sum[7:0];
			c_new = sum[8];
			h_new = hsum[4];
			v_new = (a_data[7] == rr[7]) && (res[7] != a_data[7]);
		end
		ALU_SUB, ALU_NEG: begin
			// borrow out of bit 7 and bit 3
			res = diff[7:0];
			c_new = diff[8];
			h_new = hdiff[4];
			v_new = (sub_a[7] != sub_b[7]) && (res[7] != sub_a[7]);
		end
		ALU_AND: begin
			res = a_data & rr;
			v_new = 1'b0;
		end
		ALU_OR: begin
			res = a_data | rr;
			v_new = 1'b0;
		end
		ALU_EOR: begin
			res = a_data ^ rr;
			v_new = 1'b0;
		end
		ALU_COM: begin
			res = ~a_data;
			c_new = 1'b1;
			v_new = 1'b0;
		end
		ALU_INC: begin
			res = a_data + 8'd1;
			v_new = (res == 8'h80);
		end
		ALU_DEC: begin
			res = a_data - 8'd1;
			v_new = (res == 8'h7f);
		end
		ALU_SWAP: res = {a_data[3:0], a_data[7:4]};
		ALU_LSR, ALU_ASR, ALU_ROR: begin
			// right shifts, bit 0 goes to carry and V is N xor C
			if (ctl_q.op == ALU_LSR)
				res = {1'b0, a_data[7:1]};
			else if (ctl_q.op == ALU_ASR)
				res = {a_data[7], a_data[7:1]};
			else
				res = {sreg[SREG_C], a_data[7:1]};
			c_new = a_data[0];
			v_new = res[7] ^ a_data[0];
		end
		default: res = a_data;
		endcase
	end

	// sbc, sbci and cpc only clear Z, so multi-byte compares chain
	assign sticky = (ctl_q.op == ALU_SUB) && ctl_q.carry;
	assign z_new = (res == 8'h00) && (!sticky || sreg[SREG_Z]);

	always_comb begin
		sreg_next = sreg;
		sreg_next[SREG_C] = c_new;
		sreg_next[SREG_Z] = z_new;
		sreg_next[SREG_N] = res[7];
		sreg_next[SREG_V] = v_new;
		sreg_next[SREG_S] = res[7] ^ v_new;
		sreg_next[SREG_H] = h_new;
	end

	always_ff @(posedge clk) begin
		if (reset)
			sreg <= '0;
		else if (ctl_q.flag_en)
			sreg <= sreg_next;
	end

	assign wr.we = ctl_q.store;
	assign wr.dst = ctl_q.dst;
	assign wr.data = res;

endmodule

/* design/avr_cpu.sv */
// avr_cpu
// two-stage AVR core for a subset of the 16-bit instruction set
// stage one decodes the fetched word and reads the register file,
// stage two runs the ALU, writes back and updates the status register
// program memory is a registered ROM, data memory answers in one clock
`timescale 1ns/1ns

module avr_cpu import avr_pkg::*; #(
	parameter word_t reset_pc = 16'h0000
) (
	input logic clk,
	input logic reset,
	output word_t pc,
	input word_t cdata,
	output word_t data_addr,
	output logic data_wen,
	output logic data_ren,
	input byte_t data_read,
	output byte_t data_write
);

	decoded_t dec;
	seq_state_t state;
	pc_step_t step;
	exec_ctl_t ctl;
	reg_write_t wr;
	byte_t sreg;
	byte_t a_data;
	byte_t b_data;
	word_t jump_offset;

	// pc arithmetic is 16 bits wide
	assign jump_offset = {{4{dec.offset[11]}}, dec.offset};

	avr_decode u_decode (
		.clk(clk),
		.reset(reset),
		.cdata(cdata),
		.state(state),
		.dec(dec)
	);

	avr_sequencer u_sequencer (
		.clk(clk),
		.reset(reset),
		.dec(dec),
		.cdata(cdata),
		.a_data(a_data),
		.data_read(data_read),
		.state(state),
		.step(step),
		.ctl(ctl),
		.data_addr(data_addr),
		.data_wen(data_wen),
		.data_ren(data_ren),
		.data_write(data_write)
	);

	avr_pc #(
		.reset_pc(reset_pc)
	) u_pc (
		.clk(clk),
		.reset(reset),
		.step(step),
		.offset(jump_offset),
		.flag_idx(dec.flag_idx),
		.polarity(dec.polarity),
		.sreg(sreg),
		.pc(pc)
	);

	// reads issued in decode, data arrives with the execute cycle
	avr_regfile u_regfile (
		.clk(clk),
		.reset(reset),
		.sel_a(dec.sel_a),
		.sel_b(dec.sel_b),
		.wr(wr),
		.a_data(a_data),
		.b_data(b_data)
	);

	avr_execute u_execute (
		.clk(clk),
		.reset(reset),
		.ctl(ctl),
		.a_data(a_data),
		.b_data(b_data),
		.wr(wr),
		.sreg(sreg)
	);

endmodule

/* bench/avr_cpu_tb.sv */
// avr_cpu_tb
// testbench for the two-stage AVR core
// builds a fixed program, models program ROM and data RAM, runs an
// instruction-level reference model and compares every STS in order
`timescale 1ns/1ns

module avr_cpu_tb import avr_pkg::*; ();

	localparam word_t HALT = 16'hCFFF;

	// register-register opcodes, bits 15:10
	localparam logic [5:0] RR_CPC = 6'b000001;
	localparam logic [5:0] RR_SBC = 6'b000010;
	localparam logic [5:0] RR_ADD = 6'b000011;
	localparam logic [5:0] RR_CP = 6'b000101;
	localparam logic [5:0] RR_SUB = 6'b000110;
	localparam logic [5:0] RR_ADC = 6'b000111;
	localparam logic [5:0] RR_AND = 6'b001000;
	localparam logic [5:0] RR_EOR = 6'b001001;
	localparam logic [5:0] RR_OR = 6'b001010;
	localparam logic [5:0] RR_MOV = 6'b001011;

	// immediate opcodes, bits 15:12
	localparam logic [3:0] IM_CPI = 4'h3;
	localparam logic [3:0] IM_SBCI = 4'h4;
	localparam logic [3:0] IM_SUBI = 4'h5;
	localparam logic [3:0] IM_ORI = 4'h6;
	localparam logic [3:0] IM_ANDI = 4'h7;
	localparam logic [3:0] IM_LDI = 4'hE;

	// single-register op codes, bits 3:0
	localparam logic [3:0] SG_COM = 4'h0;
	localparam logic [3:0] SG_NEG = 4'h1;
	localparam logic [3:0] SG_SWAP = 4'h2;
	localparam logic [3:0] SG_INC = 4'h3;
	localparam logic [3:0] SG_ASR = 4'h5;
	localparam logic [3:0] SG_LSR = 4'h6;
	localparam logic [3:0] SG_ROR = 4'h7;
	localparam logic [3:0] SG_DEC = 4'hA;

	logic clk;
	logic reset;
	word_t pc;
	word_t cdata;
	word_t data_addr;
	logic data_wen;
	logic data_ren;
	byte_t data_read;
	byte_t data_write;

	word_t prog [$];
	byte_t ram [256];
	word_t exp_addr [$];
	byte_t exp_data [$];
	word_t next_store;
	integer seed;
	int seen;
	int cycles;
	int limit;
	int model_count;

	// model state of the reference
	byte_t m_reg [32];
	byte_t m_sreg;
	byte_t m_ram [256];

	avr_cpu #(
		.reset_pc(16'h0000)
	) dut (
		.clk(clk),
		.reset(reset),
		.pc(pc),
		.cdata(cdata),
		.data_addr(data_addr),
		.data_wen(data_wen),
		.data_ren(data_ren),
		.data_read(data_read),
		.data_write(data_write)
	);

	initial begin
		clk = 1'b0;
		forever begin
			#10 clk = 1'b1;
			#10 clk = 0;
		end
	end

	always @(posedge clk) begin
		cycles <= cycles + 1;
	end

	// words past the program read as a jump to itself
	function automatic word_t fetch_word(word_t addr);
		if (addr < prog.size())
			return prog[addr];
		return HALT;
	endfunction

	// registered ROM and RAM, both answer 1 ns after the edge
	always @(posedge clk) begin
		word_t fetch;
		word_t raddr;
		logic rd_en;
		fetch = pc;
		raddr = data_addr;
		rd_en = data_ren;
		if (data_wen === 1'b1 && !reset)
			ram[data_addr[7:0]] = data_write;
		#1;
		cdata = fetch_word(fetch);
		if (rd_en === 1'b1)
			data_read = ram[raddr[7:0]];
	end

	task automatic check_store(word_t addr, byte_t data, word_t e_addr, byte_t e_data);
		if (addr !== e_addr || data !== e_data) begin
			$display("Mismatch at %0t: store %0d wrote %h to %h, expected %h to %h",
				$time, seen, data, addr, e_data, e_addr);
			$display("Simulation failed");
			$fatal(1, "store compare error");
		end
	endtask

	task automatic check_flagless(logic wen, logic ren);
		if (wen !== 1'b0 || ren !== 1'b0) begin
			$display("Data memory strobe active before the first store at %0t", $time);
			$display("Simulation failed");
			$fatal(1, "strobe before first store");
		end
	endtask

	// compare each data_wen event with the next expected store
	always @(posedge clk) begin
		if (!reset && data_wen === 1'b1) begin
			if (seen >= exp_addr.size()) begin
				$display("Unexpected extra store to %h at %0t", data_addr, $time);
				$display("Simulation failed");
				$fatal(1, "extra store");
			end
			check_store(data_addr, data_write, exp_addr[seen], exp_data[seen]);
			seen = seen + 1;
		end
	end

	// program builders, one per encoding
	task automatic put_word(word_t w);
		prog.push_back(w);
	endtask

	task automatic alu_rr(logic [5:0] op, reg_sel_t d, reg_sel_t r);
		put_word({op, r[4], d, r[3:0]});
	endtask

	task automatic alu_imm(logic [3:0] op, reg_sel_t d, byte_t k);
		put_word({op, k[7:4], d[3:0], k[3:0]});
	endtask

	task automatic single(logic [3:0] code, reg_sel_t d);
		put_word({7'b1001010, d, code});
	endtask

	task automatic load_byte(reg_sel_t d, word_t addr);
		put_word({7'b1001000, d, 4'h0});
		put_word(addr);
	endtask

	// stores go to consecutive addresses
	task automatic store_byte(reg_sel_t d);
		put_word({7'b1001001, d, 4'h0});
		put_word(next_store);
		next_store = next_store + 16'd1;
	endtask

	task automatic jump(logic [11:0] off);
		put_word({4'hC, off});
	endtask

	task automatic branch_clear(logic [2:0] s, logic [6:0] k);
		put_word({6'b111101, k, s});
	endtask

	// r27 becomes 1 when the flag is set, then goes out by STS
	task automatic copy_flag(logic [2:0] s);
		alu_imm(IM_LDI, 5'd27, 8'h00);
		branch_clear(s, 7'd1);
		alu_imm(IM_LDI, 5'd27, 8'h01);
		store_byte(5'd27);
	endtask

	task automatic build_program();
		next_store = 16'h0040;
		put_word(16'h0000);
		// dependent register ops back to back
		alu_imm(IM_LDI, 5'd16, 8'h5A);
		alu_imm(IM_LDI, 5'd17, 8'hC3);
		alu_rr(RR_ADD, 5'd16, 5'd17);
		alu_rr(RR_EOR, 5'd17, 5'd16);
		alu_rr(RR_SUB, 5'd17, 5'd16);
		// mul of r16 by r17 and sbrc on r17 lie outside the subset
		put_word(16'h9F01);
		put_word(16'hFD10);
		store_byte(5'd16);
		store_byte(5'd17);
		// 16-bit add and subtract chains
		alu_imm(IM_LDI, 5'd18, 8'hF0);
		alu_imm(IM_LDI, 5'd19, 8'h7F);
		alu_imm(IM_LDI, 5'd20, 8'h20);
		alu_imm(IM_LDI, 5'd21, 8'h01);
		alu_rr(RR_ADD, 5'd18, 5'd20);
		alu_rr(RR_ADC, 5'd19, 5'd21);
		store_byte(5'd18);
		store_byte(5'd19);
		copy_flag(SREG_V);
		alu_imm(IM_SUBI, 5'd18, 8'h35);
		alu_imm(IM_SBCI, 5'd19, 8'h80);
		store_byte(5'd18);
		store_byte(5'd19);
		copy_flag(SREG_C);
		// compare chains, unequal then equal
		alu_rr(RR_CP, 5'd18, 5'd20);
		alu_rr(RR_CPC, 5'd19, 5'd21);
		copy_flag(SREG_C);
		copy_flag(SREG_Z);
		alu_rr(RR_CP, 5'd20, 5'd20);
		alu_rr(RR_CPC, 5'd21, 5'd21);
		copy_flag(SREG_Z);
		// logic ops and immediates
		alu_rr(RR_AND, 5'd16, 5'd18);
		alu_rr(RR_OR, 5'd17, 5'd19);
		alu_rr(RR_MOV, 5'd28, 5'd16);
		alu_imm(IM_ANDI, 5'd28, 8'h3C);
		alu_imm(IM_ORI, 5'd28, 8'h81);
		store_byte(5'd16);
		store_byte(5'd17);
		store_byte(5'd28);
		alu_imm(IM_CPI, 5'd28, 8'hBD);
		copy_flag(SREG_Z);
		copy_flag(SREG_N);
		alu_rr(RR_SBC, 5'd16, 5'd17);
		store_byte(5'd16);
		// countdown loop, each value stored
		alu_imm(IM_LDI, 5'd22, 8'h04);
		single(SG_DEC, 5'd22);
		store_byte(5'd22);
		branch_clear(SREG_Z, 7'h7C);
		// jump over a dead store
		jump(12'd2);
		store_byte(5'd22);
		// loads from random RAM and from a stored byte
		load_byte(5'd23, 16'h0007);
		load_byte(5'd24, 16'h0008);
		alu_rr(RR_ADD, 5'd23, 5'd24);
		store_byte(5'd23);
		copy_flag(SREG_C);
		load_byte(5'd25, 16'h0041);
		alu_rr(RR_EOR, 5'd25, 5'd23);
		store_byte(5'd25);
		// single-register ops and their flags
		alu_imm(IM_LDI, 5'd26, 8'h96);
		single(SG_COM, 5'd26);
		store_byte(5'd26);
		copy_flag(SREG_C);
		single(SG_NEG, 5'd26);
		store_byte(5'd26);
		copy_flag(SREG_H);
		copy_flag(SREG_V);
		single(SG_SWAP, 5'd26);
		store_byte(5'd26);
		single(SG_LSR, 5'd26);
		store_byte(5'd26);
		copy_flag(SREG_C);
		single(SG_ASR, 5'd26);
		copy_flag(SREG_N);
		single(SG_ROR, 5'd26);
		store_byte(5'd26);
		copy_flag(SREG_C);
		alu_imm(IM_LDI, 5'd26, 8'h7F);
		single(SG_INC, 5'd26);
		store_byte(5'd26);
		copy_flag(SREG_V);
		copy_flag(SREG_S);
		put_word(HALT);
	endtask

	// N, Z, V and S follow the result and the given overflow
	function automatic void set_flags(byte_t r, logic v);
		m_sreg[SREG_Z] = (r == 8'h00);
		m_sreg[SREG_N] = r[7];
		m_sreg[SREG_V] = v;
		m_sreg[SREG_S] = r[7] ^ v;
	endfunction

	function automatic byte_t add_model(byte_t a, byte_t b, logic cin);
		byte_t r;
		r = a + b + {7'b0, cin};
		m_sreg[SREG_H] = (a[3] & b[3]) | (b[3] & ~r[3]) | (~r[3] & a[3]);
		m_sreg[SREG_C] = (a[7] & b[7]) | (b[7] & ~r[7]) | (~r[7] & a[7]);
		set_flags(r, (a[7] & b[7] & ~r[7]) | (~a[7] & ~b[7] & r[7]));
		return r;
	endfunction

	// keep_z makes Z only clear, for the carry forms
	function automatic byte_t sub_model(byte_t a, byte_t b, logic cin, logic keep_z);
		byte_t r;
		logic z_old;
		z_old = m_sreg[SREG_Z];
		r = a - b - {7'b0, cin};
		m_sreg[SREG_H] = (~a[3] & b[3]) | (b[3] & r[3]) | (r[3] & ~a[3]);
		m_sreg[SREG_C] = (~a[7] & b[7]) | (b[7] & r[7]) | (r[7] & ~a[7]);
		set_flags(r, (a[7] & ~b[7] & ~r[7]) | (~a[7] & b[7] & r[7]));
		if (keep_z)
			m_sreg[SREG_Z] = (r == 8'h00) & z_old;
		return r;
	endfunction

	function automatic void rr_model(logic [5:0] op, reg_sel_t d, reg_sel_t r);
		byte_t a;
		byte_t b;
		byte_t res;
		logic c;
		a = m_reg[d];
		b = m_reg[r];
		c = m_sreg[SREG_C];
		case (op)
		RR_CPC: res = sub_model(a, b, c, 1'b1);
		RR_SBC: m_reg[d] = sub_model(a, b, c, 1'b1);
		RR_ADD: m_reg[d] = add_model(a, b, 1'b0);
		RR_CP: res = sub_model(a, b, 1'b0, 1'b0);
		RR_SUB: m_reg[d] = sub_model(a, b, 1'b0, 1'b0);
		RR_ADC: m_reg[d] = add_model(a, b, c);
		RR_AND, RR_EOR, RR_OR: begin
			if (op == RR_AND)
				res = a & b;
			else if (op == RR_EOR)
				res = a ^ b;
			else
				res = a | b;
			set_flags(res, 1'b0);
			m_reg[d] = res;
		end
		RR_MOV: m_reg[d] = b;
		default: res = a;
		endcase
	endfunction

	function automatic void imm_model(logic [3:0] op, reg_sel_t d, byte_t k);
		byte_t res;
		case (op)
		IM_CPI: res = sub_model(m_reg[d], k, 1'b0, 1'b0);
		IM_SBCI: m_reg[d] = sub_model(m_reg[d], k, m_sreg[SREG_C], 1'b1);
		IM_SUBI: m_reg[d] = sub_model(m_reg[d], k, 1'b0, 1'b0);
		default: begin
			// ori and andi
			res = (op == IM_ORI) ? (m_reg[d] | k) : (m_reg[d] & k);
			set_flags(res, 1'b0);
			m_reg[d] = res;
		end
		endcase
	endfunction

	function automatic void single_model(logic [3:0] code, reg_sel_t d);
		byte_t a;
		byte_t r;
		a = m_reg[d];
		r = a;
		case (code)
		SG_COM: begin
			r = ~a;
			set_flags(r, 1'b0);
			m_sreg[SREG_C] = 1'b1;
		end
		SG_NEG: begin
			r = 8'h00 - a;
			m_sreg[SREG_H] = r[3] | a[3];
			m_sreg[SREG_C] = (r != 8'h00);
			set_flags(r, r == 8'h80);
		end
		SG_SWAP: r = {a[3:0], a[7:4]};
		SG_INC: begin
			r = a + 8'd1;
			set_flags(r, r == 8'h80);
		end
		SG_DEC: begin
			r = a - 8'd1;
			set_flags(r, r == 8'h7F);
		end
		SG_LSR, SG_ASR, SG_ROR: begin
			if (code == SG_LSR)
				r = {1'b0, a[7:1]};
			else if (code == SG_ASR)
				r = {a[7], a[7:1]};
			else
				r = {m_sreg[SREG_C], a[7:1]};
			m_sreg[SREG_C] = a[0];
			set_flags(r, r[7] ^ a[0]);
		end
		default: r = a;
		endcase
		m_reg[d] = r;
	endfunction

	// instruction-level run of the program, fills the expected stores
	function automatic int run_model();
		word_t pcm;
		word_t w;
		word_t addr;
		reg_sel_t rd;
		int count;
		pcm = 16'h0000;
		count = 0;
		m_sreg = 8'h00;
		while (count < 4000 && fetch_word(pcm) != HALT) begin
			w = fetch_word(pcm);
			pcm = pcm + 16'd1;
			count++;
			rd = w[8:4];
			if (w[15:12] == 4'hC) begin
				pcm = pcm + {{4{w[11]}}, w[11:0]};
			end else if (w[15:11] == 5'b11110) begin
				// brbs on bit 10 clear, brbc on bit 10 set
				if (m_sreg[w[2:0]] == !w[10])
					pcm = pcm + {{9{w[9]}}, w[9:3]};
			end else if (w[15:10] == 6'b100100 && w[3:0] == 4'h0) begin
				addr = fetch_word(pcm);
				pcm = pcm + 16'd1;
				if (w[9]) begin
					exp_addr.push_back(addr);
					exp_data.push_back(m_reg[rd]);
					m_ram[addr[7:0]] = m_reg[rd];
				end else begin
					m_reg[rd] = m_ram[addr[7:0]];
				end
			end else if (w[15:9] == 7'b1001010) begin
				single_model(w[3:0], rd);
			end else if (w[15:12] == IM_LDI) begin
				m_reg[{1'b1, w[7:4]}] = {w[11:8], w[3:0]};
			end else if (w[15:12] >= 4'h3 && w[15:12] <= 4'h7) begin
				imm_model(w[15:12], {1'b1, w[7:4]}, {w[11:8], w[3:0]});
			end else if (w[15:12] <= 4'h2) begin
				rr_model(w[15:10], rd, {w[9], w[3:0]});
			end
		end
		return count;
	endfunction

	initial begin
		reset = 1'b1;
		cdata = 16'h0000;
		data_read = 8'h00;
		seen = 0;
		cycles = 0;
		seed = 96007;
		build_program();
		for (int i = 0; i < 256; i++) begin
			ram[i] = $random(seed);
			m_ram[i] = ram[i];
		end
		model_count = run_model();
		limit = 4 * model_count + 100;

		// two reset cycles, then strobes stay low up to the first STS
		@(posedge clk);
		#2 check_flagless(data_wen, data_ren);
		@(posedge clk);
		#1 reset = 1'b0;
		#1;
		while (data_wen !== 1'b1 && cycles < limit) begin
			check_flagless(data_wen, data_ren);
			@(posedge clk);
			#2;
		end

		while (seen < exp_addr.size() && cycles < limit)
			@(posedge clk);
		#2;
		if (seen == exp_addr.size()) begin
			$display("Simulation completed successfully");
			$finish;
		end else begin
			$display("Timeout after %0d cycles, %0d of %0d stores seen",
				cycles, seen, exp_addr.size());
			$display("Simulation failed");
			$fatal(1, "timeout");
		end
	end

endmodule

/* compile.f */
design/avr_pkg.sv
design/avr_decode.sv
design/avr_sequencer.sv
design/avr_pc.sv
design/avr_regfile.sv
design/avr_execute.sv
design/avr_cpu.sv
bench/avr_cpu_tb.sv

/* run.sh */
#!/bin/sh
# build and run the AVR core testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal -f compile.f --top-module avr_cpu_tb -o avr_cpu_sim

# the simulator exits nonzero on failure, the log decides the result
./obj_dir/avr_cpu_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "Simulation failed" sim.log; then
	echo "FAIL"
	exit 1
fi
echo "PASS"
